//--- common/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // 4 ways of 8 sets, each line holds eight 32-bit words
    localparam int NUM_WAYS       = 4;
    localparam int NUM_SETS       = 8;
    localparam int WORDS_PER_LINE = 8;

    // Burst length field is beats minus one
    localparam logic [7:0] BURST_LEN = 8'd7;

    typedef logic [23:0]                  tag_t;
    typedef logic [2:0]                   set_idx_t;
    typedef logic [2:0]                   word_idx_t;
    typedef logic [NUM_WAYS-1:0]          way_mask_t;
    typedef logic [WORDS_PER_LINE*32-1:0] line_t;

    // Byte address as seen by the cache
    typedef struct packed {
        tag_t       tag;
        set_idx_t   set;
        word_idx_t  word;
        logic [1:0] byte_off;
    } cache_addr_t;

endpackage

//--- common/cache_bus_pkg.sv
package cache_bus_pkg;

    // CPU request, we is 1 for a store
    typedef struct packed {
        logic        we;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } cpu_req_t;

    // Burst request, shared by the read and write channels
    typedef struct packed {
        logic [31:0] addr;
        logic [7:0]  len;
    } mem_req_t;

    // One write data beat
    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } mem_wr_beat_t;

    // One read data beat
    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } mem_rd_beat_t;

endpackage

//--- dcache/dcache_req_decode.sv
module dcache_req_decode
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        accept_i,
    input  cpu_req_t    cpu_req_i,
    output cpu_req_t    req_o,
    output cache_addr_t addr_o,
    output logic [31:0] wmask_o
);

    logic        we_q;
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic [3:0]  wstrb_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            we_q <= 1'b0;
        end else if (accept_i) begin
            we_q <= cpu_req_i.we;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_i) begin
            addr_q  <= cpu_req_i.addr;
            wdata_q <= cpu_req_i.wdata;
            wstrb_q <= cpu_req_i.wstrb;
        end
    end

    assign req_o  = '{we: we_q, addr: addr_q, wdata: wdata_q, wstrb: wstrb_q};
    assign addr_o = cache_addr_t'(addr_q);

    // Byte strobe widened to a bit mask for the store merge
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            wmask_o[b*8 +: 8] = {8{wstrb_q[b]}};
        end
    end

endmodule

//--- dcache/dcache_ctrl.sv
module dcache_ctrl
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic cpu_req_valid_i,
    input  logic is_write_i,
    input  logic hit_i,
    input  logic victim_dirty_i,
    input  logic last_beat_i,
    input  logic cpu_rsp_ready_i,
    input  logic mem_rd_req_ready_i,
    input  logic mem_rd_rsp_valid_i,
    input  logic mem_wr_req_ready_i,
    input  logic mem_wr_ready_i,
    output logic accept_o,
    output logic cpu_req_ready_o,
    output logic cpu_rsp_valid_o,
    output logic mem_rd_req_valid_o,
    output logic mem_rd_rsp_ready_o,
    output logic mem_wr_req_valid_o,
    output logic mem_wr_valid_o,
    output logic rd_beat_o,
    output logic wr_beat_o,
    output logic fill_o,
    output logic store_o,
    output logic touch_o
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_DECIDE,
        ST_WB_REQ,
        ST_WB_BEATS,
        ST_RF_REQ,
        ST_RF_BEATS,
        ST_FILL,
        ST_STORE,
        ST_RESP
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   req_ready_q;

    // Ready is registered so it stays low through reset and rises one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            req_ready_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            req_ready_q <= (state_d == ST_IDLE);
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept_o) begin
                    state_d = ST_LOOKUP;
                end
            end
            // Arrays are read here, tags compared in decide
            ST_LOOKUP: state_d = ST_DECIDE;
            ST_DECIDE: begin
                if (hit_i) begin
                    state_d = is_write_i ? ST_IDLE : ST_RESP;
                end else if (victim_dirty_i) begin
                    state_d = ST_WB_REQ;
                end else begin
                    state_d = ST_RF_REQ;
                end
            end
            ST_WB_REQ: begin
                if (mem_wr_req_ready_i) begin
                    state_d = ST_WB_BEATS;
                end
            end
            ST_WB_BEATS: begin
                if (wr_beat_o && last_beat_i) begin
                    state_d = ST_RF_REQ;
                end
            end
            ST_RF_REQ: begin
                if (mem_rd_req_ready_i) begin
                    state_d = ST_RF_BEATS;
                end
            end
            ST_RF_BEATS: begin
                if (rd_beat_o && last_beat_i) begin
                    state_d = ST_FILL;
                end
            end
            // Write miss finishes as a store into the new line
            ST_FILL:  state_d = is_write_i ? ST_STORE : ST_RESP;
            ST_STORE: state_d = ST_IDLE;
            ST_RESP: begin
                if (cpu_rsp_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    assign cpu_req_ready_o    = req_ready_q;
    assign accept_o           = req_ready_q && cpu_req_valid_i;
    assign cpu_rsp_valid_o    = (state_q == ST_RESP);
    assign mem_wr_req_valid_o = (state_q == ST_WB_REQ);
    assign mem_wr_valid_o     = (state_q == ST_WB_BEATS);
    assign mem_rd_req_valid_o = (state_q == ST_RF_REQ);
    assign mem_rd_rsp_ready_o = (state_q == ST_RF_BEATS);

    // Datapath pulses
    assign wr_beat_o = mem_wr_valid_o && mem_wr_ready_i;
    assign rd_beat_o = mem_rd_rsp_ready_o && mem_rd_rsp_valid_i;
    assign fill_o    = (state_q == ST_FILL);
    assign store_o   = (state_q == ST_STORE) || (state_q == ST_DECIDE && hit_i && is_write_i);
    assign touch_o   = store_o || fill_o || (cpu_rsp_valid_o && cpu_rsp_ready_i);

endmodule

//--- dcache/dcache_ways.sv
module dcache_ways
    import cache_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cache_addr_t addr_i,
    input  logic [31:0] wdata_i,
    input  logic [31:0] wmask_i,
    input  line_t       fill_line_i,
    input  logic        fill_i,
    input  logic        store_i,
    input  way_mask_t   lru_way_i,
    output logic        hit_o,
    output way_mask_t   hit_way_o,
    output way_mask_t   victim_way_o,
    output logic        victim_dirty_o,
    output tag_t        victim_tag_o,
    output line_t       victim_line_o,
    output logic [31:0] rd_word_o
);

    tag_t                tag_mem  [NUM_WAYS][NUM_SETS];
    line_t               line_mem [NUM_WAYS][NUM_SETS];
    tag_t                tag_q    [NUM_WAYS];
    line_t               line_q   [NUM_WAYS];
    logic [NUM_SETS-1:0] valid_q  [NUM_WAYS];
    logic [NUM_SETS-1:0] dirty_q  [NUM_WAYS];

    way_mask_t   valid_set;
    way_mask_t   dirty_set;
    line_t       hit_line;
    logic [31:0] merged_word;
    line_t       store_line;

    // Synchronous read, a write also updates the read register
    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (fill_i && victim_way_o[w]) begin
                tag_mem[w][addr_i.set]  <= addr_i.tag;
                line_mem[w][addr_i.set] <= fill_line_i;
                tag_q[w]                <= addr_i.tag;
                line_q[w]               <= fill_line_i;
            end else if (store_i && hit_way_o[w]) begin
                line_mem[w][addr_i.set] <= store_line;
                tag_q[w]                <= tag_mem[w][addr_i.set];
                line_q[w]               <= store_line;
            end else begin
                tag_q[w]  <= tag_mem[w][addr_i.set];
                line_q[w] <= line_mem[w][addr_i.set];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (fill_i && victim_way_o[w]) begin
                    valid_q[w][addr_i.set] <= 1'b1;
                    dirty_q[w][addr_i.set] <= 1'b0;
                end else if (store_i && hit_way_o[w]) begin
                    dirty_q[w][addr_i.set] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            valid_set[w] = valid_q[w][addr_i.set];
            dirty_set[w] = dirty_q[w][addr_i.set];
            hit_way_o[w] = valid_set[w] && (tag_q[w] == addr_i.tag);
        end
    end

    assign hit_o = |hit_way_o;

    // Lowest empty way wins, a full set falls back to LRU
    always_comb begin
        victim_way_o = lru_way_i;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_set[w]) begin
                victim_way_o = way_mask_t'(1) << w;
            end
        end
    end

    always_comb begin
        hit_line      = '0;
        victim_line_o = '0;
        victim_tag_o  = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit_way_o[w]) begin
                hit_line = hit_line | line_q[w];
            end
            if (victim_way_o[w]) begin
                victim_line_o = victim_line_o | line_q[w];
                victim_tag_o  = victim_tag_o | tag_q[w];
            end
        end
    end

    assign victim_dirty_o = |(victim_way_o & valid_set & dirty_set);
    assign rd_word_o      = hit_line[addr_i.word*32 +: 32];

    // Strobed bytes replace the hit word, the rest of the line is kept
    assign merged_word = (wdata_i & wmask_i) | (rd_word_o & ~wmask_i);

    always_comb begin
        store_line = hit_line;
        store_line[addr_i.word*32 +: 32] = merged_word;
    end

endmodule

//--- dcache/dcache_lru.sv
module dcache_lru (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] set_i,
    input  logic       touch_i,
    input  logic [3:0] way_i,
    output logic [3:0] lru_way_o
);

    // Row r set bit c means way r was used after way c
    logic [3:0] matrix_q [8][4];
    logic [3:0] row_zero;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < 8; s++) begin
                for (int r = 0; r < 4; r++) begin
                    matrix_q[s][r] <= '0;
                end
            end
        end else if (touch_i) begin
            for (int r = 0; r < 4; r++) begin
                if (way_i[r]) begin
                    matrix_q[set_i][r] <= ~way_i;
                end else begin
                    matrix_q[set_i][r] <= matrix_q[set_i][r] & ~way_i;
                end
            end
        end
    end

    // Least recent way owns the all-zero row
    always_comb begin
        for (int r = 0; r < 4; r++) begin
            row_zero[r] = ~|matrix_q[set_i][r];
        end
        lru_way_o = '0;
        for (int r = 3; r >= 0; r--) begin
            if (row_zero[r]) begin
                lru_way_o = 4'b0001 << r;
            end
        end
    end

endmodule

//--- dcache/dcache_line_buf.sv
module dcache_line_buf
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         rd_beat_i,
    input  logic         wr_beat_i,
    input  logic [31:0]  rd_data_i,
    input  line_t        victim_line_i,
    output line_t        line_o,
    output mem_wr_beat_t wr_beat_o,
    output logic         last_beat_o
);

    word_idx_t beat_q;
    line_t     line_q;

    // Shared by refill and write-back, wraps to zero after eight beats
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_q <= '0;
        end else if (rd_beat_i || wr_beat_i) begin
            beat_q <= beat_q + word_idx_t'(1);
        end
    end

    // Refill words land in order of arrival
    always_ff @(posedge clk) begin
        if (rd_beat_i) begin
            line_q[beat_q*32 +: 32] <= rd_data_i;
        end
    end

    assign last_beat_o = (beat_q == word_idx_t'(WORDS_PER_LINE - 1));
    assign line_o      = line_q;

    // Write-back beats always carry full words
    assign wr_beat_o = '{
        data: victim_line_i[beat_q*32 +: 32],
        strb: 4'hF,
        last: last_beat_o
    };

endmodule

//--- dcache/dcache_top.sv
module dcache_top
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  logic         cpu_req_valid_i,
    input  cpu_req_t     cpu_req_i,
    output logic         cpu_req_ready_o,

    output logic         cpu_rsp_valid_o,
    output logic [31:0]  cpu_rsp_data_o,
    input  logic         cpu_rsp_ready_i,

    output logic         mem_rd_req_valid_o,
    output mem_req_t     mem_rd_req_o,
    input  logic         mem_rd_req_ready_i,

    input  logic         mem_rd_rsp_valid_i,
    input  mem_rd_beat_t mem_rd_rsp_i,
    output logic         mem_rd_rsp_ready_o,

    output logic         mem_wr_req_valid_o,
    output mem_req_t     mem_wr_req_o,
    input  logic         mem_wr_req_ready_i,

    output logic         mem_wr_valid_o,
    output mem_wr_beat_t mem_wr_o,
    input  logic         mem_wr_ready_i
);

    cpu_req_t    req;
    cache_addr_t addr;
    logic [31:0] wmask;

    logic        accept;
    logic        hit;
    logic        victim_dirty;
    logic        last_beat;
    logic        rd_beat;
    logic        wr_beat;
    logic        fill;
    logic        store;
    logic        touch;

    way_mask_t   hit_way;
    way_mask_t   victim_way;
    way_mask_t   lru_way;
    way_mask_t   touch_way;
    tag_t        victim_tag;
    line_t       victim_line;
    line_t       fill_line;

    // Refill fetches the requested line, write-back sends the victim line
    assign mem_rd_req_o = '{addr: {addr.tag, addr.set, 5'b0}, len: BURST_LEN};
    assign mem_wr_req_o = '{addr: {victim_tag, addr.set, 5'b0}, len: BURST_LEN};

    // A fill marks the refilled way as most recent
    assign touch_way = fill ? victim_way : hit_way;

    dcache_req_decode u_req_decode (
        .clk       (clk),
        .rst       (rst),
        .accept_i  (accept),
        .cpu_req_i (cpu_req_i),
        .req_o     (req),
        .addr_o    (addr),
        .wmask_o   (wmask)
    );

    dcache_ctrl u_ctrl (
        .clk                (clk),
        .rst                (rst),
        .cpu_req_valid_i    (cpu_req_valid_i),
        .is_write_i         (req.we),
        .hit_i              (hit),
        .victim_dirty_i     (victim_dirty),
        .last_beat_i        (last_beat),
        .cpu_rsp_ready_i    (cpu_rsp_ready_i),
        .mem_rd_req_ready_i (mem_rd_req_ready_i),
        .mem_rd_rsp_valid_i (mem_rd_rsp_valid_i),
        .mem_wr_req_ready_i (mem_wr_req_ready_i),
        .mem_wr_ready_i     (mem_wr_ready_i),
        .accept_o           (accept),
        .cpu_req_ready_o    (cpu_req_ready_o),
        .cpu_rsp_valid_o    (cpu_rsp_valid_o),
        .mem_rd_req_valid_o (mem_rd_req_valid_o),
        .mem_rd_rsp_ready_o (mem_rd_rsp_ready_o),
        .mem_wr_req_valid_o (mem_wr_req_valid_o),
        .mem_wr_valid_o     (mem_wr_valid_o),
        .rd_beat_o          (rd_beat),
        .wr_beat_o          (wr_beat),
        .fill_o             (fill),
        .store_o            (store),
        .touch_o            (touch)
    );

    dcache_ways u_ways (
        .clk            (clk),
        .rst            (rst),
        .addr_i         (addr),
        .wdata_i        (req.wdata),
        .wmask_i        (wmask),
        .fill_line_i    (fill_line),
        .fill_i         (fill),
        .store_i        (store),
        .lru_way_i      (lru_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag),
        .victim_line_o  (victim_line),
        .rd_word_o      (cpu_rsp_data_o)
    );

    dcache_lru u_lru (
        .clk       (clk),
        .rst       (rst),
        .set_i     (addr.set),
        .touch_i   (touch),
        .way_i     (touch_way),
        .lru_way_o (lru_way)
    );

    dcache_line_buf u_line_buf (
        .clk           (clk),
        .rst           (rst),
        .rd_beat_i     (rd_beat),
        .wr_beat_i     (wr_beat),
        .rd_data_i     (mem_rd_rsp_i.data),
        .victim_line_i (victim_line),
        .line_o        (fill_line),
        .wr_beat_o     (mem_wr_o),
        .last_beat_o   (last_beat)
    );

endmodule

//--- bench/tb_mem_model.sv
module tb_mem_model
    import cache_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         rd_req_valid_i,
    input  mem_req_t     rd_req_i,
    output logic         rd_req_ready_o,
    output logic         rd_rsp_valid_o,
    output mem_rd_beat_t rd_rsp_o,
    input  logic         rd_rsp_ready_i,
    input  logic         wr_req_valid_i,
    input  mem_req_t     wr_req_i,
    output logic         wr_req_ready_o,
    input  logic         wr_valid_i,
    input  mem_wr_beat_t wr_i,
    output logic         wr_ready_o
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] store [1024];
    logic [9:0]  rd_base;
    logic [9:0]  wr_base;
    logic [3:0]  rd_cnt;
    logic [3:0]  seen_cnt;
    logic [2:0]  wr_cnt;
    logic        rd_active;
    logic [31:0] rnd;

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    // Burst bookkeeping, sampled on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 1024; i++) begin
                store[10'(i)] <= lcg_step(lcg_step(32'h1248 ^ (32'(i) << 2)));
            end
            rd_active <= 1'b0;
            rd_cnt    <= '0;
            wr_cnt    <= '0;
            rd_base   <= '0;
            wr_base   <= '0;
        end else begin
            if (rd_req_valid_i && rd_req_ready_o) begin
                rd_base   <= rd_req_i.addr[11:2];
                rd_cnt    <= '0;
                rd_active <= 1'b1;
            end
            if (rd_rsp_valid_o && rd_rsp_ready_i) begin
                rd_cnt <= rd_cnt + 4'd1;
                if (rd_cnt == 4'd7) begin
                    rd_active <= 1'b0;
                end
            end
            if (wr_req_valid_i && wr_req_ready_o) begin
                wr_base <= wr_req_i.addr[11:2];
                wr_cnt  <= '0;
            end
            if (wr_valid_i && wr_ready_o) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_i.strb[b]) begin
                        store[{wr_base[9:3], wr_cnt}][b*8 +: 8] <= wr_i.data[b*8 +: 8];
                    end
                end
                wr_cnt <= wr_cnt + 3'd1;
            end
        end
    end

    // Ready and valid change on the falling edge, a raised valid waits for its transfer
    always @(negedge clk) begin
        if (rst) begin
            rnd            = 32'h1248;
            rd_req_ready_o = 1'b0;
            wr_req_ready_o = 1'b0;
            wr_ready_o     = 1'b0;
            rd_rsp_valid_o = 1'b0;
            seen_cnt       = '0;
        end else begin
            rnd            = lcg_step(rnd);
            rd_req_ready_o = rnd[20];
            wr_req_ready_o = rnd[22];
            wr_ready_o     = rnd[24] | rnd[25];
            if (!(rd_rsp_valid_o && rd_cnt == seen_cnt)) begin
                rd_rsp_valid_o = rd_active && rnd[27];
            end
            seen_cnt = rd_cnt;
        end
    end

    assign rd_rsp_o = '{data: store[{rd_base[9:3], rd_cnt[2:0]}], last: (rd_cnt == 4'd7)};

endmodule

//--- bench/tb_dcache.sv
module tb_dcache
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLE_LIMIT = 20000;
    localparam int NUM_RANDOM  = 150;

    logic         clk;
    logic         rst;
    logic         cpu_req_valid;
    cpu_req_t     cpu_req;
    logic         cpu_req_ready;
    logic         cpu_rsp_valid;
    logic [31:0]  cpu_rsp_data;
    logic         cpu_rsp_ready;
    logic         mem_rd_req_valid;
    mem_req_t     mem_rd_req;
    logic         mem_rd_req_ready;
    logic         mem_rd_rsp_valid;
    mem_rd_beat_t mem_rd_rsp;
    logic         mem_rd_rsp_ready;
    logic         mem_wr_req_valid;
    mem_req_t     mem_wr_req;
    logic         mem_wr_req_ready;
    logic         mem_wr_valid;
    mem_wr_beat_t mem_wr;
    logic         mem_wr_ready;

    // Reference memory with a copy of the tag, state and LRU arrays
    logic [31:0] shadow [1024];
    tag_t        m_tag    [NUM_SETS][NUM_WAYS];
    logic        m_valid  [NUM_SETS][NUM_WAYS];
    logic        m_dirty  [NUM_SETS][NUM_WAYS];
    logic [3:0]  m_matrix [NUM_SETS][NUM_WAYS];

    logic [31:0] exp_rd_addr;
    logic [31:0] exp_wb_addr;
    logic        exp_wb;
    logic [31:0] rng;
    int          cycles;
    int          rd_reqs;
    int          rd_beats;
    int          wr_reqs;
    int          wr_beats;
    logic [2:0]  wb_idx;
    logic        started;

    dcache_top uut (
        .clk (clk), .rst (rst),
        .cpu_req_valid_i (cpu_req_valid), .cpu_req_i (cpu_req), .cpu_req_ready_o (cpu_req_ready),
        .cpu_rsp_valid_o (cpu_rsp_valid), .cpu_rsp_data_o (cpu_rsp_data),
        .cpu_rsp_ready_i (cpu_rsp_ready),
        .mem_rd_req_valid_o (mem_rd_req_valid), .mem_rd_req_o (mem_rd_req),
        .mem_rd_req_ready_i (mem_rd_req_ready),
        .mem_rd_rsp_valid_i (mem_rd_rsp_valid), .mem_rd_rsp_i (mem_rd_rsp),
        .mem_rd_rsp_ready_o (mem_rd_rsp_ready),
        .mem_wr_req_valid_o (mem_wr_req_valid), .mem_wr_req_o (mem_wr_req),
        .mem_wr_req_ready_i (mem_wr_req_ready),
        .mem_wr_valid_o (mem_wr_valid), .mem_wr_o (mem_wr), .mem_wr_ready_i (mem_wr_ready)
    );

    tb_mem_model u_mem (
        .clk (clk), .rst (rst),
        .rd_req_valid_i (mem_rd_req_valid), .rd_req_i (mem_rd_req),
        .rd_req_ready_o (mem_rd_req_ready),
        .rd_rsp_valid_o (mem_rd_rsp_valid), .rd_rsp_o (mem_rd_rsp),
        .rd_rsp_ready_i (mem_rd_rsp_ready),
        .wr_req_valid_i (mem_wr_req_valid), .wr_req_i (mem_wr_req),
        .wr_req_ready_o (mem_wr_req_ready),
        .wr_valid_i (mem_wr_valid), .wr_i (mem_wr), .wr_ready_o (mem_wr_ready)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_error(input string msg);
        $display("FAIL at %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "stopping at first error");
    endtask

    // Touched way becomes newer than every other way of the set
    task automatic touch_way(input logic [2:0] s, input int w);
        for (int r = 0; r < NUM_WAYS; r++) begin
            if (r == w) begin
                m_matrix[s][r] = ~(4'b0001 << w);
            end else begin
                m_matrix[s][r] = m_matrix[s][r] & ~(4'b0001 << w);
            end
        end
    endtask

    function automatic int pick_victim(input logic [2:0] s);
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!m_valid[s][w]) return w;
        end
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_matrix[s][w] == 4'b0000) return w;
        end
        return 0;
    endfunction

    task automatic check_quiet();
        assert (!cpu_req_ready && !cpu_rsp_valid && !mem_rd_req_valid && !mem_wr_req_valid
                && !mem_wr_valid && !mem_rd_rsp_ready)
        else report_error("DUT output active during reset");
    endtask

    // One CPU access that starts and ends on a falling edge
    task automatic do_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wstrb);
        logic [2:0] set;
        tag_t       tag;
        logic [9:0] widx;
        int         hit_way;
        int         way;
        int         acc_cyc;
        int         rd0;
        int         rb0;
        int         wr0;
        int         wb0;
        set     = addr[7:5];
        tag     = addr[31:8];
        widx    = addr[11:2];
        hit_way = -1;
        way     = 0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[set][w] && m_tag[set][w] == tag) hit_way = w;
        end
        if (hit_way < 0) begin
            way         = pick_victim(set);
            exp_wb      = m_valid[set][way] && m_dirty[set][way];
            exp_wb_addr = {m_tag[set][way], set, 5'b0};
            exp_rd_addr = {tag, set, 5'b0};
        end
        rd0 = rd_reqs;
        rb0 = rd_beats;
        wr0 = wr_reqs;
        wb0 = wr_beats;
        cpu_req       = '{we: we, addr: addr, wdata: wdata, wstrb: wstrb};
        cpu_req_valid = 1'b1;
        while (!cpu_req_ready) @(negedge clk);
        @(negedge clk);
        acc_cyc       = cycles;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        if (!we) begin
            while (!cpu_rsp_valid) @(negedge clk);
            if (hit_way >= 0) begin
                assert (cycles - acc_cyc == 2) else report_error("read hit latency is not 2");
            end
            assert (cpu_rsp_data == shadow[widx])
            else report_error($sformatf("read %h got %h expected %h",
                                        addr, cpu_rsp_data, shadow[widx]));
            rng = lcg_step(rng);
            repeat (int'(rng[29:28])) @(negedge clk);
            cpu_rsp_ready = 1'b1;
            @(negedge clk);
            cpu_rsp_ready = 1'b0;
        end else begin
            while (!cpu_req_ready) @(negedge clk);
            if (hit_way >= 0) begin
                assert (cycles - acc_cyc == 2) else report_error("write hit latency is not 2");
            end
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) shadow[widx][b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        if (hit_way < 0) begin
            assert (rd_reqs - rd0 == 1 && rd_beats - rb0 == 8)
            else report_error("miss did not fetch exactly one 8-beat line");
            assert (wr_reqs - wr0 == int'(exp_wb) && wr_beats - wb0 == (exp_wb ? 8 : 0))
            else report_error("write-back count differs from the model");
            m_tag[set][way]   = tag;
            m_valid[set][way] = 1'b1;
            m_dirty[set][way] = 1'b0;
        end else begin
            way = hit_way;
            assert (rd_reqs == rd0 && wr_reqs == wr0) else report_error("memory traffic on a hit");
        end
        touch_way(set, way);
        if (we) m_dirty[set][way] = 1'b1;
    endtask

    // Run length limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $fatal(1, "cycle limit reached");
        end
    end

    // Channel monitor
    always @(posedge clk) begin
        if (rst) begin
            started  <= 1'b0;
            rd_reqs  <= 0;
            rd_beats <= 0;
            wr_reqs  <= 0;
            wr_beats <= 0;
            wb_idx   <= '0;
        end else begin
            if (cpu_req_valid && cpu_req_ready) started <= 1'b1;
            if (mem_rd_req_valid && mem_rd_req_ready) begin
                rd_reqs <= rd_reqs + 1;
                assert (mem_rd_req.addr == exp_rd_addr && mem_rd_req.len == BURST_LEN)
                else report_error($sformatf("refill request %h", mem_rd_req.addr));
            end
            if (mem_rd_rsp_valid && mem_rd_rsp_ready) rd_beats <= rd_beats + 1;
            if (mem_wr_req_valid && mem_wr_req_ready) begin
                wr_reqs <= wr_reqs + 1;
                wb_idx  <= '0;
                assert (exp_wb && mem_wr_req.addr == exp_wb_addr && mem_wr_req.len == BURST_LEN)
                else report_error($sformatf("write-back request %h", mem_wr_req.addr));
            end
            if (mem_wr_valid && mem_wr_ready) begin
                wr_beats <= wr_beats + 1;
                wb_idx   <= wb_idx + 3'd1;
                assert (mem_wr.data == shadow[{exp_wb_addr[11:5], wb_idx}] && mem_wr.strb == 4'hF
                        && mem_wr.last == (wb_idx == 3'd7))
                else report_error($sformatf("write-back beat %0d data %h", wb_idx, mem_wr.data));
            end
        end
    end

    a_quiet_before_start: assert property (@(posedge clk) disable iff (rst)
        !started |-> !mem_rd_req_valid && !mem_wr_req_valid && !cpu_rsp_valid)
    else report_error("activity before the first CPU request");

    a_wr_req_hold: assert property (@(posedge clk) disable iff (rst)
        mem_wr_req_valid && !mem_wr_req_ready |=> mem_wr_req_valid && $stable(mem_wr_req))
    else report_error("write request dropped before transfer");

    a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp_valid && !cpu_rsp_ready |=> cpu_rsp_valid && $stable(cpu_rsp_data))
    else report_error("CPU response dropped before transfer");

    initial begin
        clk = 1'b1;
        forever #5 clk = ~clk;
    end

    initial begin
        logic [31:0] addr;
        rst           = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        cpu_rsp_ready = 1'b0;
        rng           = 32'h1248;
        for (int i = 0; i < 1024; i++) begin
            shadow[10'(i)] = lcg_step(lcg_step(32'h1248 ^ (32'(i) << 2)));
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_tag[s][w]    = '0;
                m_valid[s][w]  = 1'b0;
                m_dirty[s][w]  = 1'b0;
                m_matrix[s][w] = '0;
            end
        end
        // Outputs are checked once a full reset cycle has passed
        for (int i = 0; i < 17; i++) begin
            @(negedge clk);
            if (i > 0) check_quiet();
        end
        rst = 1'b0;
        @(negedge clk);
        assert (cpu_req_ready && !mem_rd_req_valid && !mem_wr_req_valid)
        else report_error("cache not idle after reset");

        // Miss, hit, partial store and read back of the merged word
        do_access(1'b0, 32'h000, '0, 4'h0);
        do_access(1'b0, 32'h000, '0, 4'h0);
        do_access(1'b1, 32'h004, 32'hCAFE_BEEF, 4'b0011);
        do_access(1'b0, 32'h004, '0, 4'h0);

        // Fill set 3 with dirty lines, reorder them, then evict the oldest
        for (int t = 1; t <= 4; t++) begin
            do_access(1'b1, (32'(t) << 8) | 32'h60, 32'h1000_0000 + 32'(t), 4'hF);
        end
        do_access(1'b0, 32'h360, '0, 4'h0);
        do_access(1'b0, 32'h160, '0, 4'h0);
        do_access(1'b0, 32'h460, '0, 4'h0);
        do_access(1'b0, 32'h260, '0, 4'h0);
        do_access(1'b0, 32'h560, '0, 4'h0);
        do_access(1'b0, 32'h360, '0, 4'h0);

        for (int n = 0; n < NUM_RANDOM; n++) begin
            rng  = lcg_step(rng);
            addr = {20'b0, rng[25:16], 2'b00};
            do_access(rng[31], addr, lcg_step(rng), rng[11:8]);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- compile.f
common/cache_cfg_pkg.sv
common/cache_bus_pkg.sv
dcache/dcache_req_decode.sv
dcache/dcache_ctrl.sv
dcache/dcache_ways.sv
dcache/dcache_lru.sv
dcache/dcache_line_buf.sv
dcache/dcache_top.sv
bench/tb_mem_model.sv
bench/tb_dcache.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -j 0
TOP       := tb_dcache
FILELIST  := compile.f
OBJ_DIR   := obj_dir

.PHONY: compile run clean

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
